//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module ctrl_block_tb -o sim_ctrl_block
./obj_dir/sim_ctrl_block | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi

//--- sources.f
verilog/core_isa_pkg.sv
verilog/core_uarch_pkg.sv
verilog/stage_ifs.sv
verilog/fetch_buffer.sv
verilog/decoder.sv
verilog/rename.sv
verilog/ctrl_block.sv
tests/rename_checker.sv
tests/ctrl_block_tb.sv

//--- tests/ctrl_block_tb.sv
`default_nettype none

module ctrl_block_tb import core_uarch_pkg::*; ();
    localparam int LIMIT = 1000;

    logic              clk       = 1'b0;
    logic              rst_n     = 1'b0;
    logic [1:0]        inst_vld  = '0;
    logic [1:0][31:0]  inst      = '0;
    logic [1:0][31:0]  pred_pc   = '0;
    logic              free_vld  = 1'b0;
    logic [PREG_W-1:0] free_preg = '0;

    wire                    decode_stall;
    wire [1:0]              rename_vld;
    wire [1:0][PREG_W-1:0]  rd_preg;
    wire [1:0][PREG_W-1:0]  rs1_preg;
    wire [1:0][PREG_W-1:0]  rs2_preg;
    wire [1:0][PREG_W-1:0]  old_preg;
    wire [1:0][2:0]         op_class;
    wire [1:0][31:0]        out_pc;
    int                     chk_err;
    int                     pending;

    string             test_name    = "";
    integer            seed         = 32'h12b5;
    int                fail_cnt     = 0;
    int                test_cnt     = 0;
    int                base_err     = 0;
    int                stall_cycles = 0;
    int                stall_base   = 0;
    int                free_gap     = 0;
    logic              stop_read    = 1'b0;
    logic [PREG_W-1:0] free_q [$];

    always #2 clk = ~clk;

    ctrl_block #(
        .FETCH_WIDTH (2),
        .DECODE_WIDTH(2),
        .FB_DEPTH    (8),
        .NUM_PREG    (64)
    ) i_dut (
        .clk(clk), .i_rst_n(rst_n),
        .i_inst_vld(inst_vld), .i_inst(inst), .i_pred_pc(pred_pc),
        .o_decode_stall(decode_stall),
        .i_free_vld(free_vld), .i_free_preg(free_preg),
        .o_rename_vld(rename_vld), .o_rd_preg(rd_preg), .o_rs1_preg(rs1_preg),
        .o_rs2_preg(rs2_preg), .o_old_preg(old_preg), .o_op_class(op_class),
        .o_pred_pc(out_pc)
    );

    rename_checker u_checker (
        .clk(clk), .i_rst_n(rst_n),
        .i_inst_vld(inst_vld), .i_inst(inst), .i_pred_pc(pred_pc),
        .i_decode_stall(decode_stall), .i_free_vld(free_vld), .i_free_preg(free_preg),
        .i_rename_vld(rename_vld), .i_rd_preg(rd_preg), .i_rs1_preg(rs1_preg),
        .i_rs2_preg(rs2_preg), .i_old_preg(old_preg), .i_op_class(op_class),
        .i_out_pc(out_pc), .o_err_cnt(chk_err), .o_pending(pending)
    );

    // returns one register every six cycles so rename backs up
    always @(negedge clk) begin
        free_vld = 1'b0;
        if (free_gap > 0) begin
            free_gap = free_gap - 1;
        end else if (rst_n && free_q.size() != 0) begin
            free_preg = free_q.pop_front();
            free_vld  = 1'b1;
            free_gap  = 5;
        end
    end

    always @(posedge clk) begin
        if (decode_stall) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    task automatic note_failure(input string msg);
        $display("%s: %s", test_name, msg);
        fail_cnt++;
    endtask

    task automatic finish_test();
        int errs;
        errs = chk_err + fail_cnt - base_err;
        if (test_name != "") begin
            if (errs == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: %0d errors", test_name, errs);
            end
            test_cnt++;
        end
        base_err = chk_err + fail_cnt;
    endtask

    task automatic write_group(input logic [1:0] mask, input logic [31:0] w0,
                               input logic [31:0] p0, input logic [31:0] w1,
                               input logic [31:0] p1);
        int t;
        int gap;
        gap = $unsigned($random(seed)) % 2;
        repeat (gap) @(negedge clk);
        @(negedge clk);
        inst_vld   = mask;
        inst[0]    = w0;
        inst[1]    = w1;
        pred_pc[0] = p0;
        pred_pc[1] = p1;
        t = 0;
        while (decode_stall && t < LIMIT) begin  // fetch holds the group until there is room
            @(negedge clk);
            t++;
        end
        if (decode_stall) begin
            note_failure("fetch write held off by o_decode_stall past the timeout");
            stop_read = 1'b1;
        end
        @(negedge clk);
        inst_vld = 2'b00;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (pending != 0 && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (pending != 0) begin
            note_failure("instructions still outstanding at rename after the timeout");
            stop_read = 1'b1;
        end
    endtask

    task automatic run_cases(input int fd);
        string       cmd;
        string       rest;
        logic [31:0] arg [5];
        int          n;
        while (!stop_read && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else if (cmd == "test") begin
                finish_test();
                n = $fscanf(fd, "%s", test_name);
                u_checker.test_name = test_name;
                stall_base = stall_cycles;
            end else if (cmd == "grp") begin
                n = $fscanf(fd, "%h %h %h %h %h", arg[0], arg[1], arg[2], arg[3], arg[4]);
                write_group(arg[0][1:0], arg[1], arg[2], arg[3], arg[4]);
            end else if (cmd == "rep") begin
                n = $fscanf(fd, "%h %h %h", arg[0], arg[1], arg[2]);
                for (int g = 0; g < int'(arg[0]); g++) begin
                    write_group(2'b11, arg[1], arg[2] + 32'(8 * g), arg[1],
                                arg[2] + 32'(8 * g + 4));
                end
            end else if (cmd == "free") begin
                n = $fscanf(fd, "%h %h", arg[0], arg[1]);
                for (int f = 0; f < int'(arg[1]); f++) begin
                    free_q.push_back(PREG_W'(arg[0] + 32'(f)));
                end
            end else if (cmd == "hold") begin
                n = $fscanf(fd, "%h", arg[0]);
                repeat (int'(arg[0])) @(negedge clk);
                if (pending == 0) begin
                    note_failure("rename kept going with an empty free list");
                end
            end else if (cmd == "drain") begin
                wait_drain();
            end else if (cmd == "stallchk") begin
                if (stall_cycles == stall_base) begin
                    note_failure("o_decode_stall never rose during the burst");
                end
            end else if (cmd == "end") begin
                stop_read = 1'b1;
            end else begin
                note_failure({"unknown command ", cmd, " in the cases file"});
                stop_read = 1'b1;
            end
        end
        finish_test();
    endtask

    initial begin
        int fd;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("tests/ctrl_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/ctrl_cases.txt");
            fail_cnt++;
        end else begin
            run_cases(fd);
            $fclose(fd);
        end
        $display("%0d tests run, %0d errors", test_cnt, chk_err + fail_cnt);
        if (chk_err + fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ctrl_cases.txt
# command then hex fields: grp mask word0 pc0 word1 pc1 | rep groups word pc
# free first_preg count | hold cycles | test name | drain | stallchk | end
test alu_indep
grp 3 003100B3 00000100 00628233 00000104
grp 3 009403B3 00000108 00C58533 0000010C
drain
test dep_chain
grp 3 002086B3 00000200 00D68733 00000204
grp 1 00D707B3 00000208 00000000 00000000
grp 3 001080B3 0000020C 001080B3 00000210
drain
test x0_unused
grp 3 00208033 00000300 0020A023 00000304
grp 3 00208063 00000308 123452B7 0000030C
grp 3 000000EF 00000310 FFFFFFFF 00000314
grp 3 0040A303 00000318 FFF38413 0000031C
grp 1 000404E7 00000320 00000000 00000000
drain
test free_exhaust
rep 0A 001080B3 00001000
hold 1E
free 03 01
free 07 01
drain
test burst_stall
free 10 10
rep 08 002086B3 00002000
stallchk
drain
end

//--- tests/rename_checker.sv
`default_nettype none

module rename_checker import core_uarch_pkg::*; #(
    parameter int FETCH_WIDTH  = 2,
    parameter int DECODE_WIDTH = 2,
    parameter int NUM_PREG     = 64
) (
    input  wire logic                                clk,
    input  wire logic                                i_rst_n,
    input  wire logic [FETCH_WIDTH-1:0]              i_inst_vld,
    input  wire logic [FETCH_WIDTH-1:0][31:0]        i_inst,
    input  wire logic [FETCH_WIDTH-1:0][31:0]        i_pred_pc,
    input  wire logic                                i_decode_stall,
    input  wire logic                                i_free_vld,
    input  wire logic [PREG_W-1:0]                   i_free_preg,
    input  wire logic [DECODE_WIDTH-1:0]             i_rename_vld,
    input  wire logic [DECODE_WIDTH-1:0][PREG_W-1:0] i_rd_preg,
    input  wire logic [DECODE_WIDTH-1:0][PREG_W-1:0] i_rs1_preg,
    input  wire logic [DECODE_WIDTH-1:0][PREG_W-1:0] i_rs2_preg,
    input  wire logic [DECODE_WIDTH-1:0][PREG_W-1:0] i_old_preg,
    input  wire logic [DECODE_WIDTH-1:0][2:0]        i_op_class,
    input  wire logic [DECODE_WIDTH-1:0][31:0]       i_out_pc,
    output int                                       o_err_cnt,
    output int                                       o_pending
);
    string             test_name = "none";
    int                err_cnt   = 0;
    int                pending   = 0;
    logic [31:0]       inst_q [$];              // accepted words, program order
    logic [31:0]       pc_q   [$];
    logic [PREG_W-1:0] free_q [$];
    logic [PREG_W-1:0] rat_m  [ARCH_REGS];

    assign o_err_cnt = err_cnt;
    assign o_pending = pending;

    // {op class, uses rd, uses rs1, uses rs2} for a major opcode
    function automatic logic [5:0] expect_decode(input logic [6:0] opc);
        case (opc)
            7'h33:   expect_decode = {ALU, 3'b111};
            7'h13:   expect_decode = {ALU, 3'b110};
            7'h03:   expect_decode = {LOAD, 3'b110};
            7'h23:   expect_decode = {STORE, 3'b011};
            7'h63:   expect_decode = {BRANCH, 3'b011};
            7'h37:   expect_decode = {ALU, 3'b100};
            7'h6f:   expect_decode = {JUMP, 3'b100};
            7'h67:   expect_decode = {JUMP, 3'b110};
            default: expect_decode = {ILLEGAL, 3'b000};
        endcase
    endfunction

    task automatic compare(input int slot, input string field, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch %s slot %0d %s: expected %h, actual %h",
                     test_name, slot, field, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_slot(input int k);
        logic [31:0]       w;
        logic [31:0]       pc;
        logic [5:0]        dm;
        logic [PREG_W-1:0] e_rd;
        logic [PREG_W-1:0] e_rs1;
        logic [PREG_W-1:0] e_rs2;
        logic [PREG_W-1:0] e_old;
        if (inst_q.size() == 0) begin
            $display("%s: rename slot %0d valid with no instruction outstanding", test_name, k);
            err_cnt++;
        end else begin
            w     = inst_q.pop_front();
            pc    = pc_q.pop_front();
            dm    = expect_decode(w[6:0]);
            e_rs1 = dm[1] ? rat_m[w[19:15]] : '0;  // sources read before own rd moves
            e_rs2 = dm[0] ? rat_m[w[24:20]] : '0;
            e_rd  = '0;
            e_old = '0;
            if (dm[2] && w[11:7] != 5'd0) begin
                if (free_q.size() == 0) begin
                    $display("%s: register allocated while the free list was empty", test_name);
                    err_cnt++;
                end else begin
                    e_rd           = free_q.pop_front();
                    e_old          = rat_m[w[11:7]];
                    rat_m[w[11:7]] = e_rd;
                end
            end
            compare(k, "rd_preg", 32'(e_rd), 32'(i_rd_preg[k]));
            compare(k, "rs1_preg", 32'(e_rs1), 32'(i_rs1_preg[k]));
            compare(k, "rs2_preg", 32'(e_rs2), 32'(i_rs2_preg[k]));
            compare(k, "old_preg", 32'(e_old), 32'(i_old_preg[k]));
            compare(k, "op_class", 32'(dm[5:3]), 32'(i_op_class[k]));
            compare(k, "pred_pc", pc, i_out_pc[k]);
        end
    endtask

    always @(posedge clk) begin
        if (!i_rst_n) begin
            inst_q.delete();
            pc_q.delete();
            free_q.delete();
            for (int a = 0; a < ARCH_REGS; a++) begin
                rat_m[a] = PREG_W'(a);
            end
            for (int p = ARCH_REGS; p < NUM_PREG; p++) begin
                free_q.push_back(PREG_W'(p));
            end
        end else begin
            for (int k = 0; k < DECODE_WIDTH; k++) begin
                if (i_rename_vld[k]) begin
                    check_slot(k);
                end
            end
            if (!i_decode_stall) begin               // dropped writes never enter the model
                for (int k = 0; k < FETCH_WIDTH; k++) begin
                    if (i_inst_vld[k]) begin
                        inst_q.push_back(i_inst[k]);
                        pc_q.push_back(i_pred_pc[k]);
                    end
                end
            end
            if (i_free_vld) begin
                free_q.push_back(i_free_preg);
            end
        end
        pending = inst_q.size();
    end

endmodule

`default_nettype wire

//--- verilog/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

    localparam int XLEN = 32;                    // data and pc width
    localparam int ILEN = 32;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;                      // bit 11 is the sign
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one fetched word, seen as register format or immediate format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

endpackage

`default_nettype wire

//--- verilog/core_uarch_pkg.sv
`default_nettype none

package core_uarch_pkg;

    localparam int ARCH_REGS = 32;
    localparam int AREG_W    = 5;
    localparam int PREG_W    = 6;                // up to 64 physical regs

    typedef enum logic [2:0] {
        ALU     = 3'd0,
        LOAD    = 3'd1,
        STORE   = 3'd2,
        BRANCH  = 3'd3,
        JUMP    = 3'd4,
        ILLEGAL = 3'd7
    } op_class_e;

    typedef struct packed {
        op_class_e         op_class;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic              uses_rd;
        logic              uses_rs1;
        logic              uses_rs2;
    } dec_info_t;

endpackage

`default_nettype wire

//--- verilog/ctrl_block.sv
`default_nettype none

// fetch buffer -> decode -> rename
module ctrl_block import core_isa_pkg::*; import core_uarch_pkg::*; #(
    parameter int FETCH_WIDTH  = 2,
    parameter int DECODE_WIDTH = 2,
    parameter int FB_DEPTH     = 8,
    parameter int NUM_PREG     = 64
) (
    input  wire                                          clk,
    input  wire                                          i_rst_n,

    input  wire [FETCH_WIDTH-1:0]                        i_inst_vld,
    input  wire [FETCH_WIDTH-1:0][ILEN-1:0]              i_inst,
    input  wire [FETCH_WIDTH-1:0][XLEN-1:0]              i_pred_pc,
    output wire                                          o_decode_stall,

    input  wire                                          i_free_vld,
    input  wire [PREG_W-1:0]                             i_free_preg,

    output wire [DECODE_WIDTH-1:0]                       o_rename_vld,
    output wire [DECODE_WIDTH-1:0][PREG_W-1:0]           o_rd_preg,
    output wire [DECODE_WIDTH-1:0][PREG_W-1:0]           o_rs1_preg,
    output wire [DECODE_WIDTH-1:0][PREG_W-1:0]           o_rs2_preg,
    output wire [DECODE_WIDTH-1:0][PREG_W-1:0]           o_old_preg,
    output wire [DECODE_WIDTH-1:0][$bits(op_class_e)-1:0] o_op_class,
    output wire [DECODE_WIDTH-1:0][XLEN-1:0]             o_pred_pc
);
    fetch_q_if #(.DECODE_WIDTH(DECODE_WIDTH)) u_fetch_q ();
    dec_if     #(.DECODE_WIDTH(DECODE_WIDTH)) u_dec ();

    fetch_buffer #(
        .FETCH_WIDTH  (FETCH_WIDTH),
        .DECODE_WIDTH (DECODE_WIDTH),
        .FB_DEPTH     (FB_DEPTH)
    ) u_fetch_buffer (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_inst_vld   (i_inst_vld),
        .i_inst       (i_inst),
        .i_pred_pc    (i_pred_pc),
        .o_full_stall (o_decode_stall),
        .fq           (u_fetch_q.src)
    );

    decoder #(
        .DECODE_WIDTH (DECODE_WIDTH)
    ) u_decoder (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .fq           (u_fetch_q.dst),
        .dec          (u_dec.src)
    );

    rename #(
        .DECODE_WIDTH (DECODE_WIDTH),
        .NUM_PREG     (NUM_PREG)
    ) u_rename (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .dec          (u_dec.dst),
        .i_free_vld   (i_free_vld),
        .i_free_preg  (i_free_preg),
        .o_rename_vld (o_rename_vld),
        .o_rd_preg    (o_rd_preg),
        .o_rs1_preg   (o_rs1_preg),
        .o_rs2_preg   (o_rs2_preg),
        .o_old_preg   (o_old_preg),
        .o_op_class   (o_op_class),
        .o_pred_pc    (o_pred_pc)
    );

endmodule

`default_nettype wire

//--- verilog/decoder.sv
`default_nettype none

module decoder import core_isa_pkg::*; import core_uarch_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) (
    input wire logic clk,
    input wire logic i_rst_n,
    fetch_q_if.dst   fq,
    dec_if.src       dec
);
    dec_info_t dec_next [DECODE_WIDTH];

    function automatic dec_info_t decode_word(input inst_u w);
        dec_info_t d;
        logic      shamt_ok;
        d          = '0;
        d.op_class = ILLEGAL;
        shamt_ok   = 1'b1;
        if (w.i.funct3 == 3'b001) begin
            shamt_ok = w.i.imm12[11:5] == 7'b0;
        end else if (w.i.funct3 == 3'b101) begin
            shamt_ok = !w.i.imm12[11] && (w.i.imm12[9:5] == 5'b0);  // srai only sets bit 10
        end
        case (opcode_e'(w.r.opcode))
            OPC_OP:     begin
                d.op_class = ALU;
                d.uses_rd  = 1'b1;
                d.uses_rs1 = 1'b1;
                d.uses_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                d.op_class = shamt_ok ? ALU : ILLEGAL;
                d.uses_rd  = shamt_ok;
                d.uses_rs1 = shamt_ok;
            end
            OPC_LOAD:   begin
                d.op_class = LOAD;
                d.uses_rd  = 1'b1;
                d.uses_rs1 = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                d.op_class = (w.r.opcode == OPC_STORE) ? STORE : BRANCH;
                d.uses_rs1 = 1'b1;
                d.uses_rs2 = 1'b1;
            end
            OPC_LUI:    begin
                d.op_class = ALU;
                d.uses_rd  = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                d.op_class = JUMP;
                d.uses_rd  = 1'b1;
                d.uses_rs1 = w.r.opcode == OPC_JALR;
            end
            default:    d.op_class = ILLEGAL;
        endcase
        d.rd  = w.r.rd;
        d.rs1 = w.r.rs1;
        d.rs2 = w.r.rs2;
        return d;
    endfunction

    always_comb begin
        for (int k = 0; k < DECODE_WIDTH; k++) begin
            dec_next[k] = decode_word(fq.inst[k]);
        end
    end

    assign fq.stall = dec.stall;                // back-pressure straight to the buffer

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            dec.vld <= '0;
        end else if (!dec.stall) begin
            dec.vld <= fq.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!dec.stall) begin
            for (int k = 0; k < DECODE_WIDTH; k++) begin
                dec.info[k]    <= dec_next[k];
                dec.pred_pc[k] <= fq.pred_pc[k];
            end
        end
    end

    // entries offered by the buffer stay offered while decode is held
    a_hold_vld: assert property (@(posedge clk) disable iff (!i_rst_n)
        fq.stall |=> ((fq.vld & $past(fq.vld)) == $past(fq.vld)))
        else $error("fetch entries lost while decode stalled");

endmodule

`default_nettype wire

//--- verilog/fetch_buffer.sv
`default_nettype none

module fetch_buffer import core_isa_pkg::*; #(
    parameter int FETCH_WIDTH  = 2,
    parameter int DECODE_WIDTH = 2,
    parameter int FB_DEPTH     = 8
) (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic [FETCH_WIDTH-1:0]        i_inst_vld,
    input  wire inst_u [FETCH_WIDTH-1:0]       i_inst,
    input  wire logic [FETCH_WIDTH-1:0][XLEN-1:0] i_pred_pc,
    output logic                               o_full_stall,
    fetch_q_if.src                             fq
);
    localparam int PTR_W = $clog2(FB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    inst_u           mem_inst [FB_DEPTH];
    logic [XLEN-1:0] mem_pc   [FB_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_slots;
    logic [CNT_W-1:0] wr_num;
    logic [CNT_W-1:0] rd_num;

    assign free_slots   = CNT_W'(FB_DEPTH) - count;
    assign o_full_stall = free_slots < CNT_W'(FETCH_WIDTH);    // fetch must hold its group

    always_comb begin
        wr_num = '0;
        rd_num = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            if (i_inst_vld[k] && !o_full_stall) begin
                wr_num = wr_num + 1'b1;
            end
        end
        for (int k = 0; k < DECODE_WIDTH; k++) begin
            fq.vld[k]     = count > CNT_W'(k);
            fq.inst[k]    = mem_inst[rd_ptr + PTR_W'(k)];
            fq.pred_pc[k] = mem_pc[rd_ptr + PTR_W'(k)];
            if (fq.vld[k] && !fq.stall) begin
                rd_num = rd_num + 1'b1;         // decoder takes every valid entry
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!o_full_stall) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                if (i_inst_vld[k]) begin
                    mem_inst[wr_ptr + PTR_W'(k)] <= i_inst[k];
                    mem_pc[wr_ptr + PTR_W'(k)]   <= i_pred_pc[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(rd_num);
            wr_ptr <= wr_ptr + PTR_W'(wr_num);
            count  <= count + wr_num - rd_num;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
        count <= CNT_W'(FB_DEPTH))
        else $error("fetch buffer count above depth");

endmodule

`default_nettype wire

//--- verilog/rename.sv
`default_nettype none

module rename import core_isa_pkg::*; import core_uarch_pkg::*; #(
    parameter int DECODE_WIDTH = 2,
    parameter int NUM_PREG     = 64
) (
    input  wire logic                              clk,
    input  wire logic                              i_rst_n,
    dec_if.dst                                     dec,
    input  wire logic                              i_free_vld,
    input  wire logic [PREG_W-1:0]                 i_free_preg,
    output logic [DECODE_WIDTH-1:0]                o_rename_vld,
    output logic [DECODE_WIDTH-1:0][PREG_W-1:0]    o_rd_preg,
    output logic [DECODE_WIDTH-1:0][PREG_W-1:0]    o_rs1_preg,
    output logic [DECODE_WIDTH-1:0][PREG_W-1:0]    o_rs2_preg,
    output logic [DECODE_WIDTH-1:0][PREG_W-1:0]    o_old_preg,
    output op_class_e [DECODE_WIDTH-1:0]           o_op_class,
    output logic [DECODE_WIDTH-1:0][XLEN-1:0]      o_pred_pc
);
    localparam int FL_PTR_W = $clog2(NUM_PREG);
    localparam int FL_DEPTH = 1 << FL_PTR_W;
    localparam int FL_CNT_W = FL_PTR_W + 1;

    logic [PREG_W-1:0]   rat    [ARCH_REGS];
    logic [PREG_W-1:0]   fl_mem [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_count;
    logic [FL_CNT_W-1:0] n_alloc;
    logic                stall;

    logic [DECODE_WIDTH-1:0] alloc;
    logic [PREG_W-1:0]       new_preg [DECODE_WIDTH];
    logic [PREG_W-1:0]       src1     [DECODE_WIDTH];
    logic [PREG_W-1:0]       src2     [DECODE_WIDTH];
    logic [PREG_W-1:0]       old      [DECODE_WIDTH];

    always_comb begin
        n_alloc = '0;
        for (int k = 0; k < DECODE_WIDTH; k++) begin
            alloc[k]    = dec.vld[k] && dec.info[k].uses_rd && (dec.info[k].rd != '0);
            new_preg[k] = fl_mem[fl_head + FL_PTR_W'(n_alloc)];    // free-list order
            if (alloc[k]) begin
                n_alloc = n_alloc + 1'b1;
            end
            src1[k] = rat[dec.info[k].rs1];
            src2[k] = rat[dec.info[k].rs2];
            old[k]  = rat[dec.info[k].rd];
            for (int j = 0; j < k; j++) begin   // younger slot sees older slot's mapping
                if (alloc[j] && dec.info[j].rd == dec.info[k].rs1) src1[k] = new_preg[j];
                if (alloc[j] && dec.info[j].rd == dec.info[k].rs2) src2[k] = new_preg[j];
                if (alloc[j] && dec.info[j].rd == dec.info[k].rd)  old[k]  = new_preg[j];
            end
            if (!dec.info[k].uses_rs1) src1[k] = '0;
            if (!dec.info[k].uses_rs2) src2[k] = '0;
            if (!alloc[k]) old[k] = '0;
        end
        stall = n_alloc > fl_count;
    end

    assign dec.stall = stall;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                rat[a] <= PREG_W'(a);           // identity map
            end
            for (int f = 0; f < NUM_PREG - ARCH_REGS; f++) begin
                fl_mem[f] <= PREG_W'(ARCH_REGS + f);
            end
            fl_head  <= '0;
            fl_tail  <= FL_PTR_W'(NUM_PREG - ARCH_REGS);
            fl_count <= FL_CNT_W'(NUM_PREG - ARCH_REGS);
        end else begin
            if (!stall) begin
                for (int k = 0; k < DECODE_WIDTH; k++) begin
                    if (alloc[k]) rat[dec.info[k].rd] <= new_preg[k];
                end
            end
            if (i_free_vld) begin
                fl_mem[fl_tail] <= i_free_preg;
                fl_tail         <= fl_tail + 1'b1;
            end
            fl_head  <= fl_head + (stall ? '0 : FL_PTR_W'(n_alloc));
            fl_count <= fl_count + FL_CNT_W'(i_free_vld) - (stall ? '0 : n_alloc);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_rename_vld <= '0;
        end else begin
            o_rename_vld <= stall ? '0 : dec.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int k = 0; k < DECODE_WIDTH; k++) begin
                o_rd_preg[k]  <= alloc[k] ? new_preg[k] : '0;
                o_rs1_preg[k] <= src1[k];
                o_rs2_preg[k] <= src2[k];
                o_old_preg[k] <= old[k];
                o_op_class[k] <= dec.info[k].op_class;
                o_pred_pc[k]  <= dec.pred_pc[k];
            end
        end
    end

    a_free_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_free_vld |-> (int'(i_free_preg) < NUM_PREG))
        else $error("freed physical register out of range");

endmodule

`default_nettype wire

//--- verilog/stage_ifs.sv
`default_nettype none

// fetch buffer -> decoder
interface fetch_q_if import core_isa_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) ();
    logic [DECODE_WIDTH-1:0] vld;                // prefix of oldest entries
    inst_u                   inst    [DECODE_WIDTH];
    logic [XLEN-1:0]         pred_pc [DECODE_WIDTH];
    logic                    stall;

    modport src (output vld, inst, pred_pc, input stall);
    modport dst (input vld, inst, pred_pc, output stall);
endinterface

// decoder -> rename
interface dec_if import core_isa_pkg::*; import core_uarch_pkg::*; #(
    parameter int DECODE_WIDTH = 2
) ();
    logic [DECODE_WIDTH-1:0] vld;
    dec_info_t               info    [DECODE_WIDTH];
    logic [XLEN-1:0]         pred_pc [DECODE_WIDTH];
    logic                    stall;              // decoder holds while high

    modport src (output vld, info, pred_pc, input stall);
    modport dst (input vld, info, pred_pc, output stall);
endinterface

`default_nettype wire
